/* vlog.f */
+incdir+include
verilog/rename_pkg.sv
verilog/rename_decode.sv
verilog/rename_map.sv
verilog/rename_free_list.sv
verilog/rename_result.sv
verilog/rename_top.sv
testbench/tb_rename.sv

/* Makefile */
# Verilator build for the rename stage

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_rename
RTL_TOP   ?= rename_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SRCS := $(wildcard verilog/*.sv testbench/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_rename.sv */
// Rename stage testbench
`timescale 1ns/100ps
`include "rename_consts.svh"

module tb_rename;

  localparam int TIMEOUT = 200;  // Cycles allowed per wait

  logic                   i_clk;
  logic                   i_reset_n;
  logic                   i_flush;
  logic                   i_valid;
  logic                   o_ready;
  rename_pkg::insn_word_t i_insn;
  logic                   o_valid;
  logic                   i_ready;
  rename_pkg::renamed_t   o_op;
  logic                   i_commit_valid;
  rename_pkg::commit_t    i_commit;

  // Reference model state
  rename_pkg::phys_idx_t spec_map [`RN_NUM_ARCH];
  rename_pkg::phys_idx_t cmt_map  [`RN_NUM_ARCH];
  rename_pkg::phys_idx_t free_q   [$];
  rename_pkg::commit_t   pending_q[$];  // Renamed writers, oldest first
  rename_pkg::renamed_t  exp_q    [$];  // Ops expected at the output
  rename_pkg::renamed_t  last_op;
  rename_pkg::renamed_t  mon_exp;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          tests;
  int          failed_tests;
  int          test_start;

  rename_top u_dut (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_insn        (i_insn),
    .o_valid       (o_valid),
    .i_ready       (i_ready),
    .o_op          (o_op),
    .i_commit_valid(i_commit_valid),
    .i_commit      (i_commit)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    end
    return n;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // add rd, rs1, rs2
  function automatic rename_pkg::insn_word_t enc_op(input rename_pkg::arch_idx_t rd,
      input rename_pkg::arch_idx_t rs1, input rename_pkg::arch_idx_t rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  // addi rd, rs1, imm
  function automatic rename_pkg::insn_word_t enc_opimm(input rename_pkg::arch_idx_t rd,
      input rename_pkg::arch_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic string op_str(input rename_pkg::renamed_t op);
    return $sformatf("prs1=%0d prs2=%0d prd=%0d old_prd=%0d rd=%0d wr_rd=%0b",
                     op.prs1, op.prs2, op.prd, op.old_prd, op.rd, op.wr_rd);
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic compare_op(input rename_pkg::renamed_t got,
                            input rename_pkg::renamed_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %s", $time, what, op_str(got));
      $display("    expected %s", op_str(exp));
    end
  endtask

  task automatic compare_ready(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic start_test();
    test_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_start) begin
      $display("test %s passed", name);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", name, errors - test_start);
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  task automatic model_reset();
    for (int i = 0; i < `RN_NUM_ARCH; i++) begin
      spec_map[i] = rename_pkg::phys_idx_t'(i);
      cmt_map[i]  = rename_pkg::phys_idx_t'(i);
    end
    for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
      free_q.push_back(rename_pkg::phys_idx_t'(`RN_NUM_ARCH + i));
    end
  endtask

  // Expected rename result, taken in program order
  task automatic predict(input rename_pkg::insn_word_t insn);
    rename_pkg::renamed_t  e;
    rename_pkg::arch_idx_t rs1;
    rename_pkg::arch_idx_t rs2;
    logic                  writes;
    logic                  has_rs2;
    writes  = insn[6:0] inside {7'b0110011, 7'b0010011, 7'b0000011, 7'b0110111,
                                7'b0010111, 7'b1101111, 7'b1100111};
    has_rs2 = insn[6:0] inside {7'b0110011, 7'b0100011, 7'b1100011};
    rs1       = insn[19:15];
    rs2       = has_rs2 ? insn[24:20] : '0;
    e.rd      = insn[11:7];
    e.prs1    = spec_map[rs1];
    e.prs2    = spec_map[rs2];
    e.old_prd = spec_map[e.rd];
    e.wr_rd   = writes && (e.rd != '0);
    e.prd     = '0;
    if (e.wr_rd) begin
      if (free_q.size() == 0) begin
        report_error("model ran out of free tags");
      end else begin
        e.prd = free_q.pop_front();
        spec_map[e.rd] = e.prd;
        pending_q.push_back({e.rd, e.prd, e.old_prd});
      end
    end
    exp_q.push_back(e);
  endtask

  // Output checker, a transfer happens on the next rising edge
  always @(negedge i_clk) begin
    if (i_reset_n && o_valid && i_ready) begin
      if (exp_q.size() == 0) begin
        report_error("output op arrived with none expected");
      end else begin
        mon_exp = exp_q.pop_front();
        compare_op(o_op, mon_exp, "output op");
      end
      last_op = o_op;
    end
  end

  // --------------------------------------------------------------------------
  // Bus tasks
  // --------------------------------------------------------------------------
  task automatic send_insn(input rename_pkg::insn_word_t insn);
    int cnt;
    cnt = 0;
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_insn  <= insn;
    @(negedge i_clk);
    while (!o_ready && cnt < TIMEOUT) begin
      @(negedge i_clk);
      cnt++;
    end
    if (!o_ready) begin
      report_error("timeout waiting for o_ready");
    end
    @(posedge i_clk);
    i_valid <= 1'b0;
  endtask

  task automatic issue(input rename_pkg::insn_word_t insn);
    predict(insn);
    send_insn(insn);
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    @(negedge i_clk);
    while ((exp_q.size() != 0 || o_valid) && cnt < TIMEOUT) begin
      @(negedge i_clk);
      cnt++;
    end
    if (exp_q.size() != 0 || o_valid) begin
      report_error("timeout waiting for all expected ops to leave");
    end
  endtask

  task automatic commit_one();
    rename_pkg::commit_t c;
    if (pending_q.size() == 0) begin
      report_error("no renamed writer left to commit");
    end else begin
      c = pending_q.pop_front();
      cmt_map[c.rd] = c.prd;
      free_q.push_back(c.old_prd);  // Old mapping is dead once committed
      @(posedge i_clk);
      i_commit_valid <= 1'b1;
      i_commit       <= c;
      @(posedge i_clk);
      i_commit_valid <= 1'b0;
    end
  endtask

  task automatic commit_all();
    while (pending_q.size() > 0) begin
      commit_one();
    end
  endtask

  task automatic flush_pipe();
    rename_pkg::commit_t dropped;
    @(posedge i_clk);
    i_flush <= 1'b1;
    @(posedge i_clk);
    i_flush <= 1'b0;
    for (int i = 0; i < `RN_NUM_ARCH; i++) begin
      spec_map[i] = cmt_map[i];
    end
    // Uncommitted tags go back in front, in allocation order
    while (pending_q.size() > 0) begin
      dropped = pending_q.pop_back();
      free_q.push_front(dropped.prd);
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic check_reset_identity();
    rename_pkg::renamed_t want;
    start_test();
    @(negedge i_clk);
    compare_ready(o_valid, 1'b0, "o_valid after reset");
    compare_ready(o_ready, 1'b1, "o_ready after reset");
    issue(enc_op(5'd7, 5'd5, 5'd9));
    wait_drain();
    want.prs1    = 6'd5;
    want.prs2    = 6'd9;
    want.prd     = 6'd32;
    want.old_prd = 6'd7;
    want.rd      = 5'd7;
    want.wr_rd   = 1'b1;
    compare_op(last_op, want, "first rename");
    finish_test("reset_identity");
  endtask

  task automatic run_dependency_chain();
    rename_pkg::arch_idx_t rd;
    rename_pkg::arch_idx_t rs1;
    rename_pkg::arch_idx_t rs2;
    start_test();
    for (int n = 0; n < 20; n++) begin
      rd  = rename_pkg::arch_idx_t'(rand_bits(3));  // Few regs, many dependencies
      rs1 = rename_pkg::arch_idx_t'(rand_bits(3));
      rs2 = rename_pkg::arch_idx_t'(rand_bits(3));
      if (n % 4 == 3) begin
        issue(enc_opimm(rd, rs1, 12'(rand_bits(12))));
      end else begin
        issue(enc_op(rd, rs1, rs2));
      end
    end
    wait_drain();
    finish_test("dependency_chain");
  endtask

  task automatic exercise_x0();
    start_test();
    issue(enc_op(5'd0, 5'd0, 5'd3));      // No rd write
    issue(enc_op(5'd4, 5'd0, 5'd0));      // Takes the tag the first one left
    issue(enc_opimm(5'd0, 5'd2, 12'h7ff));
    wait_drain();
    finish_test("x0_handling");
  endtask

  task automatic exhaust_free_list();
    rename_pkg::arch_idx_t  rd;
    rename_pkg::insn_word_t stuck;
    start_test();
    commit_all();
    for (int n = 0; n < `RN_FREE_DEPTH; n++) begin
      rd = rename_pkg::arch_idx_t'(rand_bits(5));
      if (rd == '0) begin
        rd = 5'd1;
      end
      issue(enc_op(rd, rename_pkg::arch_idx_t'(rand_bits(5)), rd));
    end
    wait_drain();
    stuck = enc_op(5'd9, 5'd9, 5'd1);
    send_insn(stuck);
    for (int c = 0; c < 10; c++) begin
      @(negedge i_clk);
      compare_ready(o_valid, 1'b0, "o_valid with free list empty");
    end
    compare_ready(o_ready, 1'b0, "o_ready with writer stalled");
    commit_one();
    predict(stuck);  // Gets the tag released by that commit
    wait_drain();
    commit_all();
    finish_test("exhaustion");
  endtask

  task automatic flush_and_restore();
    rename_pkg::arch_idx_t rd;
    start_test();
    for (int n = 0; n < 6; n++) begin
      rd = rename_pkg::arch_idx_t'(rand_bits(4));
      if (rd == '0) begin
        rd = 5'd2;
      end
      issue(enc_op(rd, rename_pkg::arch_idx_t'(rand_bits(5)), rd));
    end
    wait_drain();
    repeat (3) commit_one();
    flush_pipe();
    // Read back the whole map two registers at a time
    for (int r = 0; r < `RN_NUM_ARCH; r += 2) begin
      issue(enc_op(5'd0, rename_pkg::arch_idx_t'(r), rename_pkg::arch_idx_t'(r + 1)));
    end
    issue(enc_op(5'd12, 5'd12, 5'd0));
    wait_drain();
    commit_all();
    finish_test("flush");
  endtask

  task automatic stall_output();
    rename_pkg::renamed_t held;
    int                   cnt;
    start_test();
    cnt = 0;
    @(posedge i_clk);
    i_ready <= 1'b0;
    issue(enc_op(5'd3, 5'd3, 5'd4));
    issue(enc_op(5'd4, 5'd3, 5'd3));
    @(negedge i_clk);
    while ((o_ready || !o_valid) && cnt < TIMEOUT) begin
      @(negedge i_clk);
      cnt++;
    end
    if (o_ready || !o_valid) begin
      report_error("timeout waiting for o_ready to drop under back-pressure");
    end
    held = o_op;
    for (int c = 0; c < 8; c++) begin
      @(negedge i_clk);
      compare_op(o_op, held, "stalled o_op");
    end
    compare_ready(o_ready, 1'b0, "o_ready while stalled");
    @(posedge i_clk);
    i_ready <= 1'b1;
    wait_drain();
    commit_all();
    finish_test("back_pressure");
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    i_reset_n      = 1'b0;
    i_flush        = 1'b0;
    i_valid        = 1'b0;
    i_insn         = '0;
    i_ready        = 1'b1;
    i_commit_valid = 1'b0;
    i_commit       = '0;
    lfsr_state     = 32'haebe_41a7;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    failed_tests   = 0;
    test_start     = 0;
    model_reset();
    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;

    check_reset_identity();
    run_dependency_chain();
    exercise_x0();
    exhaust_free_list();
    flush_and_restore();
    stall_output();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog/rename_top.sv */
// Register rename stage top
`timescale 1ns/100ps

module rename_top (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_flush,
  // Instruction input
  input  logic                   i_valid,
  output logic                   o_ready,
  input  rename_pkg::insn_word_t i_insn,
  // Renamed output
  output logic                   o_valid,
  input  logic                   i_ready,
  output rename_pkg::renamed_t   o_op,
  // Commit feedback
  input  logic                   i_commit_valid,
  input  rename_pkg::commit_t    i_commit
);

  logic                  w_dec_valid;
  rename_pkg::dec_op_t   w_dec_op;
  logic                  w_can_accept;
  logic                  w_fl_empty;
  logic                  w_fire;
  logic                  w_alloc;
  rename_pkg::phys_idx_t w_alloc_prd;
  rename_pkg::phys_idx_t w_prs1;
  rename_pkg::phys_idx_t w_prs2;
  rename_pkg::phys_idx_t w_old_prd;
  rename_pkg::renamed_t  w_renamed;

  // --------------------------------------------------------------------------
  // Fire condition
  // --------------------------------------------------------------------------
  // Non-writers rename without a tag
  assign w_fire  = w_dec_valid && w_can_accept && (!w_dec_op.wr_rd || !w_fl_empty);
  assign w_alloc = w_fire && w_dec_op.wr_rd;

  always_comb begin
    w_renamed.prs1    = w_prs1;
    w_renamed.prs2    = w_prs2;
    w_renamed.prd     = w_dec_op.wr_rd ? w_alloc_prd : '0;
    w_renamed.old_prd = w_old_prd;
    w_renamed.rd      = w_dec_op.rd;
    w_renamed.wr_rd   = w_dec_op.wr_rd;
  end

  rename_decode u_decode (
    .i_clk    (i_clk),
    .i_reset_n(i_reset_n),
    .i_flush  (i_flush),
    .i_valid  (i_valid),
    .o_ready  (o_ready),
    .i_insn   (i_insn),
    .o_valid  (w_dec_valid),
    .o_op     (w_dec_op),
    .i_take   (w_fire)
  );

  rename_map u_map (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rs1         (w_dec_op.rs1),
    .i_rs2         (w_dec_op.rs2),
    .i_rd          (w_dec_op.rd),
    .o_prs1        (w_prs1),
    .o_prs2        (w_prs2),
    .o_old_prd     (w_old_prd),
    .i_update      (w_alloc),
    .i_update_prd  (w_alloc_prd),
    .i_commit_valid(i_commit_valid),
    .i_commit      (i_commit),
    .i_flush       (i_flush)
  );

  rename_free_list u_free_list (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_alloc      (w_alloc),
    .o_alloc_prd  (w_alloc_prd),
    .o_empty      (w_fl_empty),
    .i_release    (i_commit_valid),
    .i_release_prd(i_commit.old_prd),  // Previous mapping is now dead
    .i_flush      (i_flush)
  );

  rename_result u_result (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_flush     (i_flush),
    .i_load      (w_fire),
    .i_op        (w_renamed),
    .o_can_accept(w_can_accept),
    .o_valid     (o_valid),
    .i_ready     (i_ready),
    .o_op        (o_op)
  );

endmodule

/* verilog/rename_result.sv */
// Rename output register
`timescale 1ns/100ps

module rename_result (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  // From rename
  input  logic                 i_load,
  input  rename_pkg::renamed_t i_op,
  output logic                 o_can_accept,
  // Downstream
  output logic                 o_valid,
  input  logic                 i_ready,
  output rename_pkg::renamed_t o_op
);

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  assign o_can_accept = !o_valid || i_ready;  // Empty or draining

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else if (i_flush) begin
      o_valid <= 1'b0;
    end else if (i_load) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;  // Drained with nothing behind
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_op <= i_op;
    end
  end

  // Stalled output holds its op until taken
  a_out_stable : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (o_valid && !i_ready && !i_flush) |=> (o_valid && $stable(o_op))
  );

endmodule

/* verilog/rename_free_list.sv */
// Physical register free list
`timescale 1ns/100ps
`include "rename_consts.svh"

module rename_free_list (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // Speculative allocation
  input  logic                  i_alloc,
  output rename_pkg::phys_idx_t o_alloc_prd,
  output logic                  o_empty,
  // Return of old tags at commit
  input  logic                  i_release,
  input  rename_pkg::phys_idx_t i_release_prd,
  input  logic                  i_flush
);

  localparam int PTR_W = $clog2(`RN_FREE_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = `RN_FREE_DEPTH;

  rename_pkg::phys_idx_t r_ring [`RN_FREE_DEPTH];
  logic [PTR_W:0]        r_head;      // Next speculative allocation
  logic [PTR_W:0]        r_cmt_head;  // Oldest uncommitted allocation
  logic [PTR_W:0]        r_tail;      // Next release slot
  logic [PTR_W:0]        w_cmt_head_next;
  logic [PTR_W:0]        w_spec_count;
  logic                  w_full;

  // --------------------------------------------------------------------------
  // Pointers
  // --------------------------------------------------------------------------
  // Commits retire in allocation order, one step per release
  assign w_cmt_head_next = i_release ? r_cmt_head + 1'b1 : r_cmt_head;
  assign w_spec_count    = r_tail - r_head;
  assign o_empty         = (r_tail == r_head);
  assign w_full          = (w_spec_count == FULL_COUNT);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head     <= '0;
      r_cmt_head <= '0;
      r_tail     <= FULL_COUNT;  // All 32 spare tags free
    end else begin
      r_cmt_head <= w_cmt_head_next;
      if (i_release) begin
        r_tail <= r_tail + 1'b1;
      end
      if (i_flush) begin
        r_head <= w_cmt_head_next;  // Drop uncommitted allocations
      end else if (i_alloc) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Tag storage
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
        r_ring[i] <= rename_pkg::phys_idx_t'(`RN_NUM_ARCH + i);  // p32 .. p63
      end
    end else if (i_release) begin
      r_ring[r_tail[PTR_W-1:0]] <= i_release_prd;
    end
  end

  assign o_alloc_prd = r_ring[r_head[PTR_W-1:0]];

  // Top only fires a writer when a tag is available
  a_no_alloc_empty : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_alloc |-> !o_empty
  );

  // A commit needs an outstanding allocation behind it
  a_no_release_full : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_release |-> !w_full
  );

endmodule

/* verilog/rename_map.sv */
// Register rename map tables
`timescale 1ns/100ps
`include "rename_consts.svh"

module rename_map (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // Lookup from decode register
  input  rename_pkg::arch_idx_t i_rs1,
  input  rename_pkg::arch_idx_t i_rs2,
  input  rename_pkg::arch_idx_t i_rd,
  output rename_pkg::phys_idx_t o_prs1,
  output rename_pkg::phys_idx_t o_prs2,
  output rename_pkg::phys_idx_t o_old_prd,
  // Speculative update on rename fire
  input  logic                  i_update,
  input  rename_pkg::phys_idx_t i_update_prd,
  // Commit and recovery
  input  logic                  i_commit_valid,
  input  rename_pkg::commit_t   i_commit,
  input  logic                  i_flush
);

  rename_pkg::phys_idx_t r_spec [`RN_NUM_ARCH];
  rename_pkg::phys_idx_t r_cmt  [`RN_NUM_ARCH];

  // --------------------------------------------------------------------------
  // Map entries
  // --------------------------------------------------------------------------
  for (genvar g = 0; g < `RN_NUM_ARCH; g++) begin : g_entry
    if (g == 0) begin : g_zero
      // x0 always lives in p0
      assign r_spec[g] = '0;
      assign r_cmt[g]  = '0;
    end else begin : g_reg
      logic                  w_commit_hit;
      logic                  w_update_hit;
      rename_pkg::phys_idx_t w_cmt_next;

      assign w_commit_hit = i_commit_valid &&
                            (i_commit.rd == rename_pkg::arch_idx_t'(g));
      assign w_update_hit = i_update && (i_rd == rename_pkg::arch_idx_t'(g));
      assign w_cmt_next   = w_commit_hit ? i_commit.prd : r_cmt[g];

      always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
          r_cmt[g] <= rename_pkg::phys_idx_t'(g);  // Identity map
        end else begin
          r_cmt[g] <= w_cmt_next;
        end
      end

      // Flush restores including a commit landing in the same cycle
      always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
          r_spec[g] <= rename_pkg::phys_idx_t'(g);
        end else if (i_flush) begin
          r_spec[g] <= w_cmt_next;
        end else if (w_update_hit) begin
          r_spec[g] <= i_update_prd;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Lookup
  // --------------------------------------------------------------------------
  // Writes land on the fire edge, so the next op sees them directly
  assign o_prs1    = r_spec[i_rs1];
  assign o_prs2    = r_spec[i_rs2];
  assign o_old_prd = r_spec[i_rd];

  // Decode drops wr_rd for x0, so rename never remaps it
  a_no_x0_update : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_update |-> (i_rd != '0)
  );

endmodule

/* verilog/rename_decode.sv */
// Rename decode stage
`timescale 1ns/100ps

module rename_decode (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_flush,
  input  logic                   i_valid,
  output logic                   o_ready,
  input  rename_pkg::insn_word_t i_insn,
  output logic                   o_valid,
  output rename_pkg::dec_op_t    o_op,
  input  logic                   i_take
);

  // RV32I major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0]          w_opcode;
  logic                w_writes_rd;
  logic                w_has_rs2;
  logic                w_accept;
  rename_pkg::dec_op_t w_dec;

  assign w_opcode = i_insn[6:0];

  // --------------------------------------------------------------------------
  // Field extraction
  // --------------------------------------------------------------------------
  always_comb begin
    case (w_opcode)
      OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_LUI,
      OPC_AUIPC, OPC_JAL, OPC_JALR: w_writes_rd = 1'b1;
      default:                      w_writes_rd = 1'b0;
    endcase
  end

  always_comb begin
    case (w_opcode)
      OPC_OP, OPC_STORE, OPC_BRANCH: w_has_rs2 = 1'b1;
      default:                       w_has_rs2 = 1'b0;
    endcase
  end

  always_comb begin
    w_dec.rs1   = i_insn[19:15];
    w_dec.rs2   = w_has_rs2 ? i_insn[24:20] : '0;  // Immediate bits otherwise
    w_dec.rd    = i_insn[11:7];
    w_dec.wr_rd = w_writes_rd && (i_insn[11:7] != '0);
  end

  // --------------------------------------------------------------------------
  // Decode register
  // --------------------------------------------------------------------------
  assign o_ready  = !o_valid || i_take;  // Empty or draining this cycle
  assign w_accept = i_valid && o_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else if (i_flush) begin
      o_valid <= 1'b0;  // Kills held op and any op arriving now
    end else if (w_accept) begin
      o_valid <= 1'b1;
    end else if (i_take) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      o_op <= w_dec;
    end
  end

  // Rename only takes an op that the register holds
  a_take_valid : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_take |-> o_valid
  );

endmodule

/* verilog/rename_pkg.sv */
// Rename stage types
`include "rename_consts.svh"

package rename_pkg;

  // --------------------------------------------------------------------------
  // Index widths
  // --------------------------------------------------------------------------
  typedef logic [`RN_ARCH_W-1:0] arch_idx_t;   // x0 .. x31
  typedef logic [`RN_PHYS_W-1:0] phys_idx_t;   // p0 .. p63
  typedef logic [31:0]           insn_word_t;

  // --------------------------------------------------------------------------
  // Stage payloads
  // --------------------------------------------------------------------------
  // Decoded register fields
  typedef struct packed {
    arch_idx_t rs1;
    arch_idx_t rs2;
    arch_idx_t rd;
    logic      wr_rd;
  } dec_op_t;

  // Renamed operation sent downstream
  typedef struct packed {
    phys_idx_t prs1;
    phys_idx_t prs2;
    phys_idx_t prd;      // Fresh tag, 0 when no rd write
    phys_idx_t old_prd;  // Freed at commit
    arch_idx_t rd;
    logic      wr_rd;
  } renamed_t;

  // Commit feedback
  typedef struct packed {
    arch_idx_t rd;
    phys_idx_t prd;
    phys_idx_t old_prd;
  } commit_t;

endpackage

/* include/rename_consts.svh */
// Rename stage constants
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Architectural register file
`define RN_NUM_ARCH   32
`define RN_ARCH_W     5

// Physical register file
`define RN_NUM_PHYS   64
`define RN_PHYS_W     6

// Free list holds every physical register not backing an arch register
`define RN_FREE_DEPTH 32

`endif
